// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held for 10 cycles, released just after an edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_tl_error_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tl_error_fabric;

  localparam int unsigned NumAccess     = 40;
  localparam int unsigned NumPut        = 30;
  localparam int unsigned NumHint       = 20;
  localparam int unsigned NumAcq        = 40;
  localparam int unsigned NumMix        = 120;
  localparam int unsigned NumTotal      = 1 + NumAccess + NumPut + NumHint + NumAcq + NumMix;
  localparam int unsigned TimeoutCycles = 200 * NumTotal;

  typedef struct packed {
    tl_err_pkg::opcode_t opcode;
    tl_err_pkg::param_t  param;
    tl_err_pkg::size_t   size;
    tl_err_pkg::source_t source;
    logic                corrupt;
  } reply_t;

  logic                clk;
  logic                rst_n;
  logic                a_valid_i;
  logic                a_ready_o;
  tl_err_pkg::opcode_t a_opcode_i;
  tl_err_pkg::param_t  a_param_i;
  tl_err_pkg::size_t   a_size_i;
  tl_err_pkg::source_t a_source_i;
  tl_err_pkg::addr_t   a_address_i;
  tl_err_pkg::data_t   a_data_i;
  logic                d_valid_o;
  logic                d_ready_i;
  tl_err_pkg::opcode_t d_opcode_o;
  tl_err_pkg::param_t  d_param_o;
  tl_err_pkg::size_t   d_size_o;
  tl_err_pkg::source_t d_source_o;
  tl_err_pkg::sink_t   d_sink_o;
  logic                d_denied_o;
  logic                d_corrupt_o;
  tl_err_pkg::data_t   d_data_o;
  logic                e_valid_i;
  tl_err_pkg::sink_t   e_sink_i;

  // model state
  reply_t                             exp_q [tl_err_pkg::NumLanes][$];
  tl_err_pkg::sink_t                  ret_q [$];
  logic [2**tl_err_pkg::SinkWidth-1:0] held = '0;
  reply_t                             cur;
  int                                 cur_lane   = 0;
  int                                 beats_left = 0;
  int                                 n_pass     = 0;
  int                                 n_fail     = 0;
  int                                 n_replies  = 0;
  int                                 ready_pct  = 100;
  int                                 cycles     = 0;
  logic                               stall_q    = 1'b0;
  tl_err_pkg::opcode_t                hold_opcode;
  tl_err_pkg::source_t                hold_source;
  tl_err_pkg::sink_t                  hold_sink;

  tb_clock_gen clock_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tl_error_fabric tl_error_fabric_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .a_valid_i   (a_valid_i),
    .a_ready_o   (a_ready_o),
    .a_opcode_i  (a_opcode_i),
    .a_param_i   (a_param_i),
    .a_size_i    (a_size_i),
    .a_source_i  (a_source_i),
    .a_address_i (a_address_i),
    .a_data_i    (a_data_i),
    .d_valid_o   (d_valid_o),
    .d_ready_i   (d_ready_i),
    .d_opcode_o  (d_opcode_o),
    .d_param_o   (d_param_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_sink_o    (d_sink_o),
    .d_denied_o  (d_denied_o),
    .d_corrupt_o (d_corrupt_o),
    .d_data_o    (d_data_o),
    .e_valid_i   (e_valid_i),
    .e_sink_i    (e_sink_i)
  );

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_opcode(string name, tl_err_pkg::opcode_t exp, tl_err_pkg::opcode_t got);
    if (got !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_param(string name, tl_err_pkg::param_t exp, tl_err_pkg::param_t got);
    if (got !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_size(string name, tl_err_pkg::size_t exp, tl_err_pkg::size_t got);
    if (got !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_source(string name, tl_err_pkg::source_t exp, tl_err_pkg::source_t got);
    if (got !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_sink(string name, tl_err_pkg::sink_t exp, tl_err_pkg::sink_t got);
    if (got !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic got);
    if (got !== exp) begin
      $display("FAIL %s expected %h got %h", name, exp, got);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic tl_err_pkg::opcode_t reply_opcode(tl_err_pkg::opcode_t op);
    case (op)
      tl_err_pkg::PutFullData, tl_err_pkg::PutPartialData: return tl_err_pkg::AccessAck;
      tl_err_pkg::ArithmeticData, tl_err_pkg::LogicalData, tl_err_pkg::Get: begin
        return tl_err_pkg::AccessAckData;
      end
      tl_err_pkg::Intent: return tl_err_pkg::HintAck;
      default: return tl_err_pkg::Grant;
    endcase
  endfunction

  // 4-byte beats, one beat for anything without data
  function automatic int req_beats(tl_err_pkg::opcode_t op, tl_err_pkg::size_t size);
    if (op <= tl_err_pkg::LogicalData && size > 2) begin
      return 1 << (size - 2);
    end
    return 1;
  endfunction

  function automatic int reply_beats(tl_err_pkg::opcode_t op, tl_err_pkg::size_t size);
    if (op == tl_err_pkg::AccessAckData && size > 2) begin
      return 1 << (size - 2);
    end
    return 1;
  endfunction

  task automatic send_request(tl_err_pkg::opcode_t op, tl_err_pkg::size_t size,
                              tl_err_pkg::source_t source, tl_err_pkg::lane_t lane);
    tl_err_pkg::addr_t addr;
    reply_t            item;
    int                beats;
    beats = req_beats(op, size);
    addr  = $urandom;
    addr[tl_err_pkg::LaneSelLsb +: tl_err_pkg::LaneBits] = lane;
    item.opcode  = reply_opcode(op);
    item.param   = (item.opcode == tl_err_pkg::Grant) ? tl_err_pkg::ToN : '0;
    item.size    = size;
    item.source  = source;
    item.corrupt = item.opcode == tl_err_pkg::AccessAckData;
    a_opcode_i  = op;
    a_param_i   = (op >= tl_err_pkg::AcquireBlock) ?
                  tl_err_pkg::param_t'($urandom_range(2, 0)) : '0;
    a_size_i    = size;
    a_source_i  = source;
    a_address_i = addr;
    for (int b = 0; b < beats; b++) begin
      a_valid_i = 1'b1;
      a_data_i  = $urandom;
      do begin
        @(posedge clk);
      end while (!a_ready_o);
      #1;
      // the reply is owed once the last beat is taken
      if (b == beats - 1) begin
        exp_q[lane].push_back(item);
      end
    end
    a_valid_i = 1'b0;
  endtask

  task automatic take_beat();
    int found;
    found = -1;
    if (beats_left == 0) begin
      // a new burst, find the lane whose oldest reply it is
      for (int l = 0; l < tl_err_pkg::NumLanes; l++) begin
        if (found < 0 && exp_q[l].size() > 0 && exp_q[l][0].opcode == d_opcode_o &&
            exp_q[l][0].size == d_size_o && exp_q[l][0].source == d_source_o &&
            (d_opcode_o != tl_err_pkg::Grant || d_sink_o / tl_err_pkg::SinksPerLane == l)) begin
          found = l;
        end
      end
      if (found < 0) begin
        $display("unexpected reply: no lane waits for opcode %h size %h source %h sink %h",
                 d_opcode_o, d_size_o, d_source_o, d_sink_o);
        n_fail++;
        return;
      end
      cur_lane   = found;
      cur        = exp_q[found][0];
      beats_left = reply_beats(cur.opcode, cur.size);
      if (cur.opcode == tl_err_pkg::Grant) begin
        check_flag("d_sink_o free", 1'b1, !held[d_sink_o]);
        held[d_sink_o] = 1'b1;
        ret_q.push_back(d_sink_o);
      end
    end
    check_opcode("d_opcode_o", cur.opcode, d_opcode_o);
    check_param("d_param_o", cur.param, d_param_o);
    check_size("d_size_o", cur.size, d_size_o);
    check_source("d_source_o", cur.source, d_source_o);
    check_flag("d_denied_o", 1'b1, d_denied_o);
    check_flag("d_corrupt_o", cur.corrupt, d_corrupt_o);
    check_flag("d_data_o zero", 1'b1, d_data_o == '0);
    beats_left--;
    if (beats_left == 0) begin
      void'(exp_q[cur_lane].pop_front());
      n_replies++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // monitors and background drivers
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      check_flag("d_valid_o in reset", 1'b0, d_valid_o);
    end else begin
      // a stalled beat keeps its fields
      if (stall_q) begin
        check_flag("d_valid_o held", 1'b1, d_valid_o);
        check_opcode("d_opcode_o held", hold_opcode, d_opcode_o);
        check_source("d_source_o held", hold_source, d_source_o);
        check_sink("d_sink_o held", hold_sink, d_sink_o);
      end
      if (d_valid_o && d_ready_i) begin
        take_beat();
      end
      if (e_valid_i) begin
        held[e_sink_i] = 1'b0;
      end
      stall_q     = d_valid_o && !d_ready_i;
      hold_opcode = d_opcode_o;
      hold_source = d_source_o;
      hold_sink   = d_sink_o;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("timeout: no progress within %0d cycles", TimeoutCycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // the ready level is picked up at the edge, tests change it between edges
  initial begin : ready_driver
    int pct;
    d_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      pct = ready_pct;
      #1;
      d_ready_i = $urandom_range(99, 0) < pct;
    end
  end

  // GrantAck for a random outstanding id after a random delay
  initial begin : e_sender
    int idx;
    e_valid_i = 1'b0;
    e_sink_i  = '0;
    forever begin
      @(posedge clk);
      #1;
      e_valid_i = 1'b0;
      if (rst_n && ret_q.size() > 0 && $urandom_range(5, 0) == 0) begin
        idx       = $urandom_range(ret_q.size() - 1, 0);
        e_sink_i  = ret_q[idx];
        ret_q.delete(idx);
        e_valid_i = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  // kind 0 access, 1 put, 2 intent, 3 acquire, 4 any opcode
  task automatic run_test(string name, int kind, int count, int pct, int max_gap);
    tl_err_pkg::opcode_t op;
    tl_err_pkg::size_t   size;
    int                  gap;
    int                  fails_before;
    int                  replies_before;
    fails_before   = n_fail;
    replies_before = n_replies;
    ready_pct      = pct;
    for (int i = 0; i < count; i++) begin
      case (kind)
        0: op = tl_err_pkg::opcode_t'($urandom_range(4, 2));
        1: op = tl_err_pkg::opcode_t'($urandom_range(1, 0));
        2: op = tl_err_pkg::Intent;
        3: op = tl_err_pkg::opcode_t'($urandom_range(7, 6));
        default: op = tl_err_pkg::opcode_t'($urandom_range(7, 0));
      endcase
      size = (kind == 1) ? tl_err_pkg::size_t'($urandom_range(4, 3)) :
                           tl_err_pkg::size_t'($urandom_range(tl_err_pkg::MaxSize, 0));
      send_request(op, size, tl_err_pkg::source_t'($urandom),
                   tl_err_pkg::lane_t'($urandom_range(tl_err_pkg::NumLanes - 1, 0)));
      gap = $urandom_range(max_gap, 0);
      if (gap > 0) begin
        repeat (gap) @(posedge clk);
        #1;
      end
    end
    // drain every lane
    while (beats_left != 0 || exp_q[0].size() != 0 || exp_q[1].size() != 0 ||
           exp_q[2].size() != 0 || exp_q[3].size() != 0) begin
      @(posedge clk);
      #1;
    end
    // every reply came once, so nothing more may show up
    repeat (4) begin
      @(posedge clk);
      check_flag("d_valid_o after drain", 1'b0, d_valid_o);
    end
    #1;
    $display("test %s: %0d requests, %0d replies, %0d errors", name, count,
             n_replies - replies_before, n_fail - fails_before);
  endtask

  initial begin
    void'($urandom(40201));
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_param_i   = '0;
    a_size_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_data_i    = '0;
    @(posedge rst_n);
    repeat (3) begin
      @(posedge clk);
      check_flag("d_valid_o after reset", 1'b0, d_valid_o);
    end
    #1;
    run_test("first request after reset", 0, 1, 100, 0);
    run_test("access", 0, NumAccess, 75, 3);
    run_test("put", 1, NumPut, 75, 3);
    run_test("intent", 2, NumHint, 75, 3);
    run_test("acquire", 3, NumAcq, 75, 2);
    run_test("all lanes busy", 4, NumMix, 30, 0);
    $display("checks passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tl_burst_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_burst_tracker (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                a_valid_i,
  input  wire logic                a_ready_i,
  input  wire tl_err_pkg::opcode_t a_opcode_i,
  input  wire tl_err_pkg::size_t   a_size_i,
  input  wire logic                d_valid_i,
  input  wire logic                d_ready_i,
  input  wire tl_err_pkg::opcode_t d_opcode_i,
  input  wire tl_err_pkg::size_t   d_size_i,
  output logic                     a_last_o,
  output logic                     d_first_o,
  output logic                     d_last_o
);

  tl_err_pkg::beat_cnt_t a_cnt_q;
  tl_err_pkg::beat_cnt_t d_cnt_q;
  tl_err_pkg::beat_cnt_t a_len;
  tl_err_pkg::beat_cnt_t d_len;

  // beats in the current message, minus one
  assign a_len = tl_err_pkg::burst_len(a_size_i, tl_err_pkg::a_has_data(a_opcode_i));
  assign d_len = tl_err_pkg::burst_len(d_size_i, tl_err_pkg::d_has_data(d_opcode_i));

  assign a_last_o  = a_cnt_q == a_len;
  assign d_first_o = d_cnt_q == '0;
  assign d_last_o  = d_cnt_q == d_len;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_cnt_q <= '0;
      d_cnt_q <= '0;
    end else begin
      if (a_valid_i && a_ready_i) begin
        a_cnt_q <= a_last_o ? '0 : a_cnt_q + 1'b1;
      end
      if (d_valid_i && d_ready_i) begin
        d_cnt_q <= d_last_o ? '0 : d_cnt_q + 1'b1;
      end
    end
  end

  // the beat count comes from the size, so it must not move mid burst
  d_size_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && !d_first_o |-> $stable(d_size_i));

endmodule

`default_nettype wire

// ==== tl_err_pkg.sv ====
`default_nettype none

package tl_err_pkg;

  ////////////////////////////////////////////////////////////
  // channel widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned SourceWidth = 4;
  localparam int unsigned SinkWidth   = 3;
  localparam int unsigned SizeWidth   = 3;
  localparam int unsigned MaxSize     = 4;
  localparam int unsigned BeatBytes   = DataWidth / 8;

  // lane layout, lane n owns sinks n*SinksPerLane and up
  localparam int unsigned NumLanes     = 4;
  localparam int unsigned LaneBits     = $clog2(NumLanes);
  localparam int unsigned SinksPerLane = 2;
  localparam int unsigned LaneSinkBits = $clog2(SinksPerLane);
  localparam int unsigned LaneSelLsb   = 12;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [SourceWidth-1:0] source_t;
  typedef logic [SinkWidth-1:0]   sink_t;
  typedef logic [SizeWidth-1:0]   size_t;
  typedef logic [LaneBits-1:0]    lane_t;
  typedef logic [$clog2((2 ** MaxSize) / BeatBytes)-1:0] beat_cnt_t;
  typedef logic [2:0]             opcode_t;
  typedef logic [2:0]             param_t;

  // A channel opcodes
  localparam opcode_t PutFullData    = 3'd0;
  localparam opcode_t PutPartialData = 3'd1;
  localparam opcode_t ArithmeticData = 3'd2;
  localparam opcode_t LogicalData    = 3'd3;
  localparam opcode_t Get            = 3'd4;
  localparam opcode_t Intent         = 3'd5;
  localparam opcode_t AcquireBlock   = 3'd6;
  localparam opcode_t AcquirePerm    = 3'd7;

  // D channel opcodes
  localparam opcode_t AccessAck     = 3'd0;
  localparam opcode_t AccessAckData = 3'd1;
  localparam opcode_t HintAck       = 3'd2;
  localparam opcode_t Grant         = 3'd4;
  localparam opcode_t GrantData     = 3'd5;

  // cap permission for a Grant
  localparam param_t ToN = 3'd2;

  typedef enum logic [1:0] {
    slot_idle_e,
    slot_wait_sink_e,
    slot_busy_e
  } lane_state_e;

  function automatic logic a_has_data(opcode_t op);
    return op inside {PutFullData, PutPartialData, ArithmeticData, LogicalData};
  endfunction

  function automatic logic d_has_data(opcode_t op);
    return op inside {AccessAckData, GrantData};
  endfunction

  // number of beats minus one
  function automatic beat_cnt_t burst_len(size_t size, logic has_data);
    int unsigned bytes;
    bytes = 1 << ((size > MaxSize) ? MaxSize : size);
    if (!has_data || bytes <= BeatBytes) begin
      return '0;
    end
    return beat_cnt_t'(bytes / BeatBytes - 1);
  endfunction

endpackage

`default_nettype wire

// ==== tl_error_fabric.f ====
tl_err_pkg.sv
tl_burst_tracker.sv
tl_error_lane.sv
tl_req_demux.sv
tl_resp_arbiter.sv
tl_error_fabric.sv
tb_clock_gen.sv
tb_tl_error_fabric.sv

// ==== tl_error_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_error_fabric (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                a_valid_i,
  output logic                     a_ready_o,
  input  wire tl_err_pkg::opcode_t a_opcode_i,
  input  wire tl_err_pkg::param_t  a_param_i,
  input  wire tl_err_pkg::size_t   a_size_i,
  input  wire tl_err_pkg::source_t a_source_i,
  input  wire tl_err_pkg::addr_t   a_address_i,
  input  wire tl_err_pkg::data_t   a_data_i,
  output logic                     d_valid_o,
  input  wire logic                d_ready_i,
  output tl_err_pkg::opcode_t      d_opcode_o,
  output tl_err_pkg::param_t       d_param_o,
  output tl_err_pkg::size_t        d_size_o,
  output tl_err_pkg::source_t      d_source_o,
  output tl_err_pkg::sink_t        d_sink_o,
  output logic                     d_denied_o,
  output logic                     d_corrupt_o,
  output tl_err_pkg::data_t        d_data_o,
  input  wire logic                e_valid_i,
  input  wire tl_err_pkg::sink_t   e_sink_i
);

  logic [tl_err_pkg::NumLanes-1:0] lane_a_valid;
  logic [tl_err_pkg::NumLanes-1:0] lane_a_ready;
  logic [tl_err_pkg::NumLanes-1:0] lane_e_valid;
  logic [tl_err_pkg::NumLanes-1:0] lane_d_valid;
  logic [tl_err_pkg::NumLanes-1:0] lane_d_ready;
  logic [tl_err_pkg::NumLanes-1:0] lane_d_last;
  logic [tl_err_pkg::NumLanes-1:0] lane_d_denied;
  logic [tl_err_pkg::NumLanes-1:0] lane_d_corrupt;
  tl_err_pkg::opcode_t             lane_d_opcode [tl_err_pkg::NumLanes];
  tl_err_pkg::param_t              lane_d_param [tl_err_pkg::NumLanes];
  tl_err_pkg::size_t               lane_d_size [tl_err_pkg::NumLanes];
  tl_err_pkg::source_t             lane_d_source [tl_err_pkg::NumLanes];
  tl_err_pkg::sink_t               lane_d_sink [tl_err_pkg::NumLanes];

  tl_req_demux req_demux_i (
    .a_valid_i      (a_valid_i),
    .a_ready_o      (a_ready_o),
    .a_address_i    (a_address_i),
    .lane_a_valid_o (lane_a_valid),
    .lane_a_ready_i (lane_a_ready),
    .e_valid_i      (e_valid_i),
    .e_sink_i       (e_sink_i),
    .lane_e_valid_o (lane_e_valid)
  );

  // A fields are shared, only valid is steered
  for (genvar i = 0; i < tl_err_pkg::NumLanes; i++) begin : gen_lane
    tl_error_lane #(
      .LaneIdx (i)
    ) lane_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .a_valid_i   (lane_a_valid[i]),
      .a_ready_o   (lane_a_ready[i]),
      .a_opcode_i  (a_opcode_i),
      .a_size_i    (a_size_i),
      .a_source_i  (a_source_i),
      .d_valid_o   (lane_d_valid[i]),
      .d_ready_i   (lane_d_ready[i]),
      .d_opcode_o  (lane_d_opcode[i]),
      .d_param_o   (lane_d_param[i]),
      .d_size_o    (lane_d_size[i]),
      .d_source_o  (lane_d_source[i]),
      .d_sink_o    (lane_d_sink[i]),
      .d_denied_o  (lane_d_denied[i]),
      .d_corrupt_o (lane_d_corrupt[i]),
      .d_last_o    (lane_d_last[i]),
      .e_valid_i   (lane_e_valid[i]),
      .e_sink_i    (e_sink_i)
    );
  end

  tl_resp_arbiter resp_arbiter_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lane_d_valid_i   (lane_d_valid),
    .lane_d_ready_o   (lane_d_ready),
    .lane_d_last_i    (lane_d_last),
    .lane_d_opcode_i  (lane_d_opcode),
    .lane_d_param_i   (lane_d_param),
    .lane_d_size_i    (lane_d_size),
    .lane_d_source_i  (lane_d_source),
    .lane_d_sink_i    (lane_d_sink),
    .lane_d_denied_i  (lane_d_denied),
    .lane_d_corrupt_i (lane_d_corrupt),
    .d_valid_o        (d_valid_o),
    .d_ready_i        (d_ready_i),
    .d_opcode_o       (d_opcode_o),
    .d_param_o        (d_param_o),
    .d_size_o         (d_size_o),
    .d_source_o       (d_source_o),
    .d_sink_o         (d_sink_o),
    .d_denied_o       (d_denied_o),
    .d_corrupt_o      (d_corrupt_o),
    .d_data_o         (d_data_o)
  );

endmodule

`default_nettype wire

// ==== tl_error_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_error_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                a_valid_i,
  output logic                     a_ready_o,
  input  wire tl_err_pkg::opcode_t a_opcode_i,
  input  wire tl_err_pkg::size_t   a_size_i,
  input  wire tl_err_pkg::source_t a_source_i,
  output logic                     d_valid_o,
  input  wire logic                d_ready_i,
  output tl_err_pkg::opcode_t      d_opcode_o,
  output tl_err_pkg::param_t       d_param_o,
  output tl_err_pkg::size_t        d_size_o,
  output tl_err_pkg::source_t      d_source_o,
  output tl_err_pkg::sink_t        d_sink_o,
  output logic                     d_denied_o,
  output logic                     d_corrupt_o,
  output logic                     d_last_o,
  input  wire logic                e_valid_i,
  input  wire tl_err_pkg::sink_t   e_sink_i
);

  localparam tl_err_pkg::sink_t SinkBase =
    tl_err_pkg::sink_t'(LaneIdx * tl_err_pkg::SinksPerLane);

  tl_err_pkg::lane_state_e state_q;
  tl_err_pkg::lane_state_e state_d;

  logic a_last;
  logic d_first;
  logic load;
  logic d_fire;

  // reply slot
  tl_err_pkg::opcode_t rsp_opcode;
  tl_err_pkg::param_t  rsp_param;
  tl_err_pkg::opcode_t opcode_q;
  tl_err_pkg::param_t  param_q;
  tl_err_pkg::size_t   size_q;
  tl_err_pkg::source_t source_q;

  // sink ids of this lane, a set bit means free
  logic [tl_err_pkg::SinksPerLane-1:0] free_q;
  logic [tl_err_pkg::SinksPerLane-1:0] free_d;
  logic [tl_err_pkg::LaneSinkBits-1:0] avail_idx;
  logic [tl_err_pkg::LaneSinkBits-1:0] sink_q;
  logic [tl_err_pkg::LaneSinkBits-1:0] e_idx;
  logic                                sink_avail;

  tl_burst_tracker burst_tracker_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .a_valid_i  (a_valid_i),
    .a_ready_i  (a_ready_o),
    .a_opcode_i (a_opcode_i),
    .a_size_i   (a_size_i),
    .d_valid_i  (d_valid_o),
    .d_ready_i  (d_ready_i),
    .d_opcode_i (d_opcode_o),
    .d_size_i   (d_size_o),
    .a_last_o   (a_last),
    .d_first_o  (d_first),
    .d_last_o   (d_last_o)
  );

  // only the last beat needs room in the slot
  assign a_ready_o = !a_last || state_q == tl_err_pkg::slot_idle_e;
  assign load      = a_valid_i && a_ready_o && a_last;
  assign d_fire    = d_valid_o && d_ready_i;

  always_comb begin
    rsp_opcode = tl_err_pkg::AccessAck;
    rsp_param  = '0;
    case (a_opcode_i)
      tl_err_pkg::PutFullData, tl_err_pkg::PutPartialData: begin
        rsp_opcode = tl_err_pkg::AccessAck;
      end
      tl_err_pkg::ArithmeticData, tl_err_pkg::LogicalData, tl_err_pkg::Get: begin
        rsp_opcode = tl_err_pkg::AccessAckData;
      end
      tl_err_pkg::Intent: begin
        rsp_opcode = tl_err_pkg::HintAck;
      end
      tl_err_pkg::AcquireBlock, tl_err_pkg::AcquirePerm: begin
        rsp_opcode = tl_err_pkg::Grant;
        rsp_param  = tl_err_pkg::ToN;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // slot FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      tl_err_pkg::slot_idle_e: begin
        if (load) begin
          state_d = (rsp_opcode == tl_err_pkg::Grant && !sink_avail) ?
                    tl_err_pkg::slot_wait_sink_e : tl_err_pkg::slot_busy_e;
        end
      end
      tl_err_pkg::slot_wait_sink_e: begin
        if (sink_avail) begin
          state_d = tl_err_pkg::slot_busy_e;
        end
      end
      tl_err_pkg::slot_busy_e: begin
        if (d_fire && d_last_o) begin
          state_d = tl_err_pkg::slot_idle_e;
        end
      end
      default: state_d = tl_err_pkg::slot_idle_e;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= tl_err_pkg::slot_idle_e;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      opcode_q <= rsp_opcode;
      param_q  <= rsp_param;
      size_q   <= a_size_i;
      source_q <= a_source_i;
    end
    // pick the id as the reply goes out so the sink field holds
    if (state_d == tl_err_pkg::slot_busy_e && state_q != tl_err_pkg::slot_busy_e) begin
      sink_q <= avail_idx;
    end
  end

  assign d_valid_o   = state_q == tl_err_pkg::slot_busy_e;
  assign d_opcode_o  = opcode_q;
  assign d_param_o   = param_q;
  assign d_size_o    = size_q;
  assign d_source_o  = source_q;
  assign d_sink_o    = SinkBase | tl_err_pkg::sink_t'(sink_q);
  assign d_denied_o  = 1'b1;
  assign d_corrupt_o = opcode_q == tl_err_pkg::AccessAckData;

  ////////////////////////////////////////////////////////////
  // sink id pool
  ////////////////////////////////////////////////////////////

  // lowest free id wins
  always_comb begin
    sink_avail = 1'b0;
    avail_idx  = '0;
    for (int i = tl_err_pkg::SinksPerLane - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        sink_avail = 1'b1;
        avail_idx  = i[tl_err_pkg::LaneSinkBits-1:0];
      end
    end
  end

  assign e_idx = e_sink_i[tl_err_pkg::LaneSinkBits-1:0];

  always_comb begin
    free_d = free_q;
    if (d_fire && d_first && opcode_q == tl_err_pkg::Grant) begin
      free_d[sink_q] = 1'b0;
    end
    // GrantAck returns the id
    if (e_valid_i) begin
      free_d[e_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_q <= '1;
    end else begin
      free_q <= free_d;
    end
  end

  e_sink_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    e_valid_i |-> !free_q[e_idx]);

  // a Grant only goes out with an id that is still free
  no_reply_without_sink_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && d_first && opcode_q == tl_err_pkg::Grant |-> free_q[sink_q]);

endmodule

`default_nettype wire

// ==== tl_req_demux.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_req_demux (
  input  wire logic                              a_valid_i,
  output logic                                   a_ready_o,
  input  wire tl_err_pkg::addr_t                 a_address_i,
  output logic [tl_err_pkg::NumLanes-1:0]        lane_a_valid_o,
  input  wire logic [tl_err_pkg::NumLanes-1:0]   lane_a_ready_i,
  input  wire logic                              e_valid_i,
  input  wire tl_err_pkg::sink_t                 e_sink_i,
  output logic [tl_err_pkg::NumLanes-1:0]        lane_e_valid_o
);

  tl_err_pkg::lane_t a_lane;
  tl_err_pkg::lane_t e_lane;
  tl_err_pkg::sink_t e_lane_full;

  // lane select sits just above the per-lane address window
  assign a_lane = a_address_i[tl_err_pkg::LaneSelLsb +: tl_err_pkg::LaneBits];

  // sink id divided by SinksPerLane
  assign e_lane_full = e_sink_i >> tl_err_pkg::LaneSinkBits;
  assign e_lane      = e_lane_full[tl_err_pkg::LaneBits-1:0];

  always_comb begin
    lane_a_valid_o         = '0;
    lane_e_valid_o         = '0;
    lane_a_valid_o[a_lane] = a_valid_i;
    lane_e_valid_o[e_lane] = e_valid_i;
  end

  assign a_ready_o = lane_a_ready_i[a_lane];

endmodule

`default_nettype wire

// ==== tl_resp_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_resp_arbiter (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [tl_err_pkg::NumLanes-1:0]   lane_d_valid_i,
  output logic [tl_err_pkg::NumLanes-1:0]        lane_d_ready_o,
  input  wire logic [tl_err_pkg::NumLanes-1:0]   lane_d_last_i,
  input  wire tl_err_pkg::opcode_t               lane_d_opcode_i [tl_err_pkg::NumLanes],
  input  wire tl_err_pkg::param_t                lane_d_param_i [tl_err_pkg::NumLanes],
  input  wire tl_err_pkg::size_t                 lane_d_size_i [tl_err_pkg::NumLanes],
  input  wire tl_err_pkg::source_t               lane_d_source_i [tl_err_pkg::NumLanes],
  input  wire tl_err_pkg::sink_t                 lane_d_sink_i [tl_err_pkg::NumLanes],
  input  wire logic [tl_err_pkg::NumLanes-1:0]   lane_d_denied_i,
  input  wire logic [tl_err_pkg::NumLanes-1:0]   lane_d_corrupt_i,
  output logic                                   d_valid_o,
  input  wire logic                              d_ready_i,
  output tl_err_pkg::opcode_t                    d_opcode_o,
  output tl_err_pkg::param_t                     d_param_o,
  output tl_err_pkg::size_t                      d_size_o,
  output tl_err_pkg::source_t                    d_source_o,
  output tl_err_pkg::sink_t                      d_sink_o,
  output logic                                   d_denied_o,
  output logic                                   d_corrupt_o,
  output tl_err_pkg::data_t                      d_data_o
);

  tl_err_pkg::lane_t ptr_q;
  tl_err_pkg::lane_t grant_q;
  tl_err_pkg::lane_t sel;
  logic              lock_q;
  logic              lock_d;
  logic              burst_done;

  // search from the pointer, unless a burst holds the grant
  always_comb begin
    tl_err_pkg::lane_t cand;
    sel  = lock_q ? grant_q : ptr_q;
    cand = ptr_q;
    if (!lock_q) begin
      for (int i = tl_err_pkg::NumLanes - 1; i >= 0; i--) begin
        cand = tl_err_pkg::lane_t'((int'(ptr_q) + i) % tl_err_pkg::NumLanes);
        if (lane_d_valid_i[cand]) begin
          sel = cand;
        end
      end
    end
  end

  assign d_valid_o   = lane_d_valid_i[sel];
  assign d_opcode_o  = lane_d_opcode_i[sel];
  assign d_param_o   = lane_d_param_i[sel];
  assign d_size_o    = lane_d_size_i[sel];
  assign d_source_o  = lane_d_source_i[sel];
  assign d_sink_o    = lane_d_sink_i[sel];
  assign d_denied_o  = lane_d_denied_i[sel];
  assign d_corrupt_o = lane_d_corrupt_i[sel];
  // error lanes never return real data
  assign d_data_o    = '0;

  always_comb begin
    lane_d_ready_o      = '0;
    lane_d_ready_o[sel] = d_ready_i;
  end

  // a presented beat keeps the grant until the last beat goes
  assign burst_done = d_valid_o && d_ready_i && lane_d_last_i[sel];
  assign lock_d     = d_valid_o && !burst_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q   <= '0;
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else begin
      lock_q  <= lock_d;
      grant_q <= sel;
      if (burst_done) begin
        ptr_q <= tl_err_pkg::lane_t'((int'(sel) + 1) % tl_err_pkg::NumLanes);
      end
    end
  end

  // lanes keep valid up for the whole burst
  grant_locked_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lock_q |-> lane_d_valid_i[grant_q]);

endmodule

`default_nettype wire
